// ==== design/flit_if.sv ====
`timescale 1ns/1ps

interface flit_if
    import noc_pkg::*;
();

    flit_t     tdata;
    logic      tlast;
    logic      tvalid;
    logic      tready;
    port_idx_t port;      // Output picked by the route decoder.

    modport sender (
        output tdata,
        output tlast,
        output tvalid,
        output port,
        input  tready
    );

    modport receiver (
        input  tdata,
        input  tlast,
        input  tvalid,
        input  port,
        output tready
    );

endinterface

// ==== design/input_queue.sv ====
`timescale 1ns/1ps

module input_queue
    import noc_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)(
    input  logic   clk,
    input  logic   arst_n_i,
    input  flit_t  in_tdata_i,
    input  logic   in_tlast_i,
    input  logic   in_tvalid_i,
    output logic   in_tready_o,
    flit_if.sender deq
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    flit_t            data_mem [FIFO_DEPTH];
    logic             last_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             wr_en;
    logic             rd_en;

    assign in_tready_o = (count_q != CNT_W'(FIFO_DEPTH));
    assign wr_en       = in_tvalid_i && in_tready_o;
    assign rd_en       = deq.tvalid && deq.tready;

    assign deq.tvalid = (count_q != '0);
    assign deq.tdata  = data_mem[rd_ptr_q];
    assign deq.tlast  = last_mem[rd_ptr_q];
    assign deq.port   = PORT_LOCAL;   // Filled in by route_xy.

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_ptr_q] <= in_tdata_i;
            last_mem[wr_ptr_q] <= in_tlast_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;    // Both or neither.
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n_i)
        (count_q <= CNT_W'(FIFO_DEPTH)) &&
        ((int'(wr_ptr_q) - int'(rd_ptr_q) + FIFO_DEPTH) % FIFO_DEPTH ==
         int'(count_q) % FIFO_DEPTH))
        else $error("input_queue: occupancy above FIFO_DEPTH or out of step with pointers");

endmodule

// ==== design/mesh_router.sv ====
`timescale 1ns/1ps

module mesh_router
    import noc_pkg::*;
#(
    parameter coord_t ROUTER_X   = 2'd0,
    parameter coord_t ROUTER_Y   = 2'd0,
    parameter int     FIFO_DEPTH = 4
)(
    input  logic  clk,
    input  logic  arst_n_i,
    input  flit_t in_tdata_i   [NUM_PORTS],
    input  logic  in_tlast_i   [NUM_PORTS],
    input  logic  in_tvalid_i  [NUM_PORTS],
    output logic  in_tready_o  [NUM_PORTS],
    output flit_t out_tdata_o  [NUM_PORTS],
    output logic  out_tlast_o  [NUM_PORTS],
    output logic  out_tvalid_o [NUM_PORTS],
    input  logic  out_tready_i [NUM_PORTS]
);

    flit_if queue_out [NUM_PORTS] ();
    flit_if route_out [NUM_PORTS] ();
    flit_if arb_out ();

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_chan
        input_queue #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_queue (
            .clk         (clk),
            .arst_n_i    (arst_n_i),
            .in_tdata_i  (in_tdata_i[i]),
            .in_tlast_i  (in_tlast_i[i]),
            .in_tvalid_i (in_tvalid_i[i]),
            .in_tready_o (in_tready_o[i]),
            .deq         (queue_out[i])
        );

        route_xy #(
            .ROUTER_X (ROUTER_X),
            .ROUTER_Y (ROUTER_Y)
        ) u_route (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .up       (queue_out[i]),
            .down     (route_out[i])
        );
    end

    // One packet crosses the router at a time.
    packet_arbiter u_arbiter (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req      (route_out),
        .grant    (arb_out)
    );

    output_switch u_switch (
        .in           (arb_out),
        .out_tdata_o  (out_tdata_o),
        .out_tlast_o  (out_tlast_o),
        .out_tvalid_o (out_tvalid_o),
        .out_tready_i (out_tready_i)
    );

endmodule

// ==== design/noc_pkg.sv ====
package noc_pkg;

    localparam int FLIT_W    = 32;
    localparam int COORD_W   = 2;
    localparam int NUM_PORTS = 5;

    // Destination fields inside a head flit.
    localparam int DST_X_LSB = 0;
    localparam int DST_Y_LSB = 2;

    typedef logic [FLIT_W-1:0]  flit_t;
    typedef logic [COORD_W-1:0] coord_t;    // 4x4 mesh.
    typedef logic [2:0]         port_idx_t;

    // North is Y+1, east is X+1.
    localparam port_idx_t PORT_LOCAL = 3'd0;
    localparam port_idx_t PORT_NORTH = 3'd1;
    localparam port_idx_t PORT_EAST  = 3'd2;
    localparam port_idx_t PORT_SOUTH = 3'd3;
    localparam port_idx_t PORT_WEST  = 3'd4;

    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1    // Locked to one input until tlast.
    } arb_state_t;

endpackage

// ==== design/output_switch.sv ====
`timescale 1ns/1ps

module output_switch
    import noc_pkg::*;
(
    flit_if.receiver in,
    output flit_t    out_tdata_o  [NUM_PORTS],
    output logic     out_tlast_o  [NUM_PORTS],
    output logic     out_tvalid_o [NUM_PORTS],
    input  logic     out_tready_i [NUM_PORTS]
);

    logic [NUM_PORTS-1:0] valid_vec;
    logic                 port_ok;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_out
        assign valid_vec[i]    = in.tvalid && (in.port == port_idx_t'(i));
        assign out_tvalid_o[i] = valid_vec[i];
        assign out_tdata_o[i]  = in.tdata;     // Shared by all outputs.
        assign out_tlast_o[i]  = in.tlast;
    end

    assign port_ok  = (in.port < port_idx_t'(NUM_PORTS));

    // Ready comes back only from the addressed output.
    assign in.tready = port_ok ? out_tready_i[in.port] : 1'b0;

    a_one_valid: assert final (!in.tvalid || $onehot(valid_vec))
        else $error("output_switch: valid flit not on exactly one output");

endmodule

// ==== design/packet_arbiter.sv ====
`timescale 1ns/1ps

module packet_arbiter
    import noc_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    flit_if.receiver req [NUM_PORTS],
    flit_if.sender   grant
);

    arb_state_t           state_q;
    port_idx_t            rr_ptr_q;     // Last input served.
    port_idx_t            owner_q;
    logic                 pend_q;       // Head offered, not yet taken.
    port_idx_t            winner;
    port_idx_t            sel;
    logic                 any_valid;
    logic                 xfer;
    logic [NUM_PORTS-1:0] req_valid;
    logic [NUM_PORTS-1:0] req_last;
    flit_t                req_data [NUM_PORTS];
    port_idx_t            req_port [NUM_PORTS];

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_req
        assign req_valid[i]  = req[i].tvalid;
        assign req_last[i]   = req[i].tlast;
        assign req_data[i]   = req[i].tdata;
        assign req_port[i]   = req[i].port;
        assign req[i].tready = grant.tready && (sel == port_idx_t'(i));
    end

    // Search starts one past the last input served.
    always_comb begin
        int idx;
        winner    = rr_ptr_q;
        any_valid = 1'b0;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            idx = (int'(rr_ptr_q) + k) % NUM_PORTS;
            if (!any_valid && req_valid[idx]) begin
                winner    = port_idx_t'(idx);
                any_valid = 1'b1;
            end
        end
    end

    assign sel = ((state_q == ARB_BUSY) || pend_q) ? owner_q : winner;

    assign grant.tvalid = req_valid[sel];
    assign grant.tdata  = req_data[sel];
    assign grant.tlast  = req_last[sel];
    assign grant.port   = req_port[sel];
    assign xfer         = grant.tvalid && grant.tready;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= ARB_IDLE;
            rr_ptr_q <= PORT_LOCAL;
            owner_q  <= PORT_LOCAL;
            pend_q   <= 1'b0;
        end else begin
            if (grant.tvalid) begin
                owner_q <= sel;
            end
            case (state_q)
                ARB_IDLE: begin
                    pend_q <= grant.tvalid && !grant.tready;
                    if (xfer && !grant.tlast) begin
                        state_q <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (xfer && grant.tlast) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
            if (xfer && grant.tlast) begin
                rr_ptr_q <= sel;    // Packet done.
            end
        end
    end

    a_grant_locked: assert property (@(posedge clk) disable iff (!arst_n_i)
        (((state_q == ARB_BUSY) && !(xfer && grant.tlast)) ||
         (grant.tvalid && !grant.tready))
        |=> (sel == $past(sel)))
        else $error("packet_arbiter: grant moved inside a packet or a stalled offer");

endmodule

// ==== design/route_xy.sv ====
`timescale 1ns/1ps

module route_xy
    import noc_pkg::*;
#(
    parameter coord_t ROUTER_X = 2'd0,
    parameter coord_t ROUTER_Y = 2'd0
)(
    input  logic     clk,
    input  logic     arst_n_i,
    flit_if.receiver up,
    flit_if.sender   down
);

    logic      head_q;      // Next flit starts a packet.
    port_idx_t port_q;
    port_idx_t head_port;
    coord_t    dst_x;
    coord_t    dst_y;
    logic      xfer;

    assign dst_x = up.tdata[DST_X_LSB +: COORD_W];
    assign dst_y = up.tdata[DST_Y_LSB +: COORD_W];

    // X first, then Y.
    always_comb begin
        if (dst_x > ROUTER_X) begin
            head_port = PORT_EAST;
        end else if (dst_x < ROUTER_X) begin
            head_port = PORT_WEST;
        end else if (dst_y > ROUTER_Y) begin
            head_port = PORT_NORTH;
        end else if (dst_y < ROUTER_Y) begin
            head_port = PORT_SOUTH;
        end else begin
            head_port = PORT_LOCAL;
        end
    end

    assign xfer = up.tvalid && down.tready;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q <= 1'b1;
        end else if (xfer) begin
            head_q <= up.tlast;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer && head_q) begin
            port_q <= head_port;    // Held for the body flits.
        end
    end

    assign down.port   = head_q ? head_port : port_q;
    assign down.tdata  = up.tdata;
    assign down.tlast  = up.tlast;
    assign down.tvalid = up.tvalid;
    assign up.tready   = down.tready;

endmodule

// ==== mesh_router.f ====
design/noc_pkg.sv
design/flit_if.sv
design/input_queue.sv
design/route_xy.sv
design/packet_arbiter.sv
design/output_switch.sv
design/mesh_router.sv
verification/mesh_router_tb.sv

// ==== verification/mesh_router_tb.sv ====
`timescale 1ns/1ps

module mesh_router_tb
    import noc_pkg::*;
();

    localparam coord_t ROUTER_X    = 2'd1;
    localparam coord_t ROUTER_Y    = 2'd2;
    localparam int     FIFO_DEPTH  = 4;
    localparam int     PKTS_PER_IN = 12;

    logic  clk;
    logic  arst_n_i;
    flit_t in_tdata_i   [NUM_PORTS];
    logic  in_tlast_i   [NUM_PORTS];
    logic  in_tvalid_i  [NUM_PORTS];
    logic  in_tready_o  [NUM_PORTS];
    flit_t out_tdata_o  [NUM_PORTS];
    logic  out_tlast_o  [NUM_PORTS];
    logic  out_tvalid_o [NUM_PORTS];
    logic  out_tready_i [NUM_PORTS];

    integer      seed = 32'h5369_c514;
    int          len_tab [NUM_PORTS][PKTS_PER_IN];
    int          limit;
    int          cycles;
    int          acc [NUM_PORTS];        // Flits accepted per input.
    int          drn [NUM_PORTS];        // Flits delivered per input.
    int          pkt_cnt [NUM_PORTS];    // Packets delivered per input.
    logic        owed [NUM_PORTS][NUM_PORTS];   // Input b is owed a turn before input a.
    logic        pkt_active;
    int          pkt_src;
    int          pkt_out;
    logic        stall_q [NUM_PORTS];
    flit_t       stall_data [NUM_PORTS];
    logic [32:0] exp_q [NUM_PORTS][NUM_PORTS][$];   // {last, flit} per output and source.

    mesh_router #(
        .ROUTER_X   (ROUTER_X),
        .ROUTER_Y   (ROUTER_Y),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_mesh_router (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // X first, then Y. North is Y+1, east is X+1.
    function automatic port_idx_t expected_port(input coord_t dx, input coord_t dy);
        if (dx != ROUTER_X) return (dx > ROUTER_X) ? PORT_EAST : PORT_WEST;
        if (dy != ROUTER_Y) return (dy > ROUTER_Y) ? PORT_NORTH : PORT_SOUTH;
        return PORT_LOCAL;
    endfunction

    function automatic logic all_drained();
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int s = 0; s < NUM_PORTS; s++) begin
                if (exp_q[o][s].size() != 0) return 1'b0;
            end
        end
        return !pkt_active;
    endfunction

    task automatic send_stream(input int ch);
        logic [31:0] rnd;
        flit_t       f;
        port_idx_t   op;
        int          len;
        for (int p = 0; p < PKTS_PER_IN; p++) begin
            len = len_tab[ch][p];
            rnd = $random(seed);
            op  = expected_port(rnd[1:0], rnd[3:2]);
            for (int k = 0; k < len; k++) begin
                @(negedge clk);
                f = $random(seed);
                if (k == 0) begin
                    f[3:0] = rnd[3:0];          // Destination Y, X.
                end else begin
                    f[23:16] = 8'(k);           // Body sequence tag.
                end
                f[6:4]  = 3'(ch);
                f[15:8] = 8'(p);
                in_tdata_i[ch]  = f;
                in_tlast_i[ch]  = (k == len - 1);
                in_tvalid_i[ch] = 1'b1;
                exp_q[op][ch].push_back({k == len - 1, f});
                do @(posedge clk); while (!in_tready_o[ch]);
            end
            rnd = $random(seed);
            repeat (rnd[1:0] % 3) begin
                @(negedge clk);
                in_tvalid_i[ch] = 1'b0;
            end
        end
        @(negedge clk);
        in_tvalid_i[ch] = 1'b0;
    endtask

    task automatic check_flit(input int o);
        logic [32:0] exp;
        int          src;
        src = int'(out_tdata_o[o][6:4]);
        assert (src < NUM_PORTS && exp_q[o][src].size() != 0)
            else abort_run($sformatf("unexpected flit %h on output %0d at %0t",
                                     out_tdata_o[o], o, $time));
        exp = exp_q[o][src].pop_front();
        assert (out_tdata_o[o] == exp[31:0])
            else abort_run($sformatf("mismatch at %0t: out_tdata_o[%0d] expected %h actual %h",
                                     $time, o, exp[31:0], out_tdata_o[o]));
        assert (out_tlast_o[o] == exp[32])
            else abort_run($sformatf("mismatch at %0t: out_tlast_o[%0d] expected %0b actual %0b",
                                     $time, o, exp[32], out_tlast_o[o]));
        if (!pkt_active) begin
            assert (int'(out_tdata_o[o][15:8]) == pkt_cnt[src])
                else abort_run($sformatf("mismatch at %0t: out_tdata_o[%0d] packet expected %0d actual %0d",
                                         $time, o, pkt_cnt[src], out_tdata_o[o][15:8]));
            for (int w = 0; w < NUM_PORTS; w++) begin
                assert (!owed[src][w])
                    else abort_run($sformatf("input %0d served twice while input %0d waited",
                                             src, w));
            end
            for (int w = 0; w < NUM_PORTS; w++) begin
                owed[w][src] = 1'b0;
                owed[src][w] = (w != src) && (acc[w] > drn[w]);
            end
            pkt_active = 1'b1;
            pkt_src    = src;
            pkt_out    = o;
        end else begin
            assert (src == pkt_src && o == pkt_out)
                else abort_run($sformatf("packet from input %0d interleaved on output %0d at %0t",
                                         src, o, $time));
        end
        if (out_tlast_o[o]) begin
            pkt_active = 1'b0;
            pkt_cnt[src]++;
        end
        drn[src]++;
    endtask

    always @(posedge clk) begin
        if (arst_n_i) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                assert (in_tready_o[i] == ((acc[i] - drn[i]) < FIFO_DEPTH))
                    else abort_run($sformatf("mismatch at %0t: in_tready_o[%0d] expected %0b actual %0b",
                                             $time, i, (acc[i] - drn[i]) < FIFO_DEPTH,
                                             in_tready_o[i]));
            end
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (stall_q[o]) begin   // Held since last edge.
                    assert (out_tvalid_o[o])
                        else abort_run($sformatf("mismatch at %0t: out_tvalid_o[%0d] expected 1 actual %0b",
                                                 $time, o, out_tvalid_o[o]));
                    assert (out_tdata_o[o] == stall_data[o])
                        else abort_run($sformatf("mismatch at %0t: out_tdata_o[%0d] expected %h actual %h",
                                                 $time, o, stall_data[o], out_tdata_o[o]));
                end
                stall_q[o]    = out_tvalid_o[o] && !out_tready_i[o];
                stall_data[o] = out_tdata_o[o];
                if (out_tvalid_o[o] && out_tready_i[o]) check_flit(o);
            end
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (in_tvalid_i[i] && in_tready_o[i]) acc[i]++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            abort_run($sformatf("timeout after %0d cycles, packets still in flight", cycles));
        end
    end

    // Random back-pressure plus a window where every output stalls.
    initial begin
        logic [31:0] rnd;
        int          cyc;
        cyc = 0;
        wait (arst_n_i);
        forever begin
            @(negedge clk);
            cyc++;
            for (int o = 0; o < NUM_PORTS; o++) begin
                rnd = $random(seed);
                out_tready_i[o] = (cyc >= 40 && cyc < 90) ? 1'b0 : (rnd[1:0] != 2'b00);
            end
        end
    end

    initial begin
        int total;
        arst_n_i   = 1'b0;
        pkt_active = 1'b0;
        cycles     = 0;
        total      = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            in_tdata_i[i]   = '0;
            in_tlast_i[i]   = 1'b0;
            in_tvalid_i[i]  = 1'b0;
            out_tready_i[i] = 1'b1;
            acc[i]          = 0;
            drn[i]          = 0;
            pkt_cnt[i]      = 0;
            stall_q[i]      = 1'b0;
            for (int j = 0; j < NUM_PORTS; j++) owed[i][j] = 1'b0;
            for (int p = 0; p < PKTS_PER_IN; p++) begin
                len_tab[i][p] = 1 + ($unsigned($random(seed)) % 4);
                total += len_tab[i][p];
            end
        end
        limit = 40 * total + 200;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        @(posedge clk);
        for (int i = 0; i < NUM_PORTS; i++) begin
            assert (!out_tvalid_o[i] && in_tready_o[i])
                else abort_run($sformatf("port %0d not idle after reset", i));
        end
        for (int c = 0; c < NUM_PORTS; c++) begin
            fork
                automatic int ch = c;
                send_stream(ch);
            join_none
        end
        wait fork;
        while (!all_drained()) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule
